/* hw/systolic_pkg.sv */
// unsigned operands only; ACC_W holds full sums for SIZE up to 16 at DATA_W of 8
`default_nettype none

package systolic_pkg;

    // element and partial-sum widths
    localparam int DATA_W       = 8;
    localparam int ACC_W        = 20;

    // array dimension used when the top level sets nothing else
    localparam int SIZE_DEFAULT = 4;

    // one A or B element
    typedef logic [DATA_W-1:0] elem_t;

    // one partial sum, also one C element
    typedef logic [ACC_W-1:0] acc_t;

    // block controller
    typedef enum logic [2:0] {
        IDLE,
        WAIT_OPERANDS,
        FEED,
        DRAIN,
        OUTPUT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/slice_if.sv */
// one slice stream; a beat moves when valid and ready are high, done marks beat SIZE
`timescale 1ns/10ps
`default_nettype none

interface slice_if #(
    parameter int W = 32
);
    logic         valid;
    logic [W-1:0] data;
    logic         done;
    logic         ready;

    // producer side
    modport source (
        output valid,
        output data,
        output done,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  done,
        output ready
    );

endinterface

`default_nettype wire

/* hw/systolic_pe.sv */
// unsigned MAC cell; a weight bank must be written before its first use
`timescale 1ns/10ps
`default_nettype none

module systolic_pe (
    input  logic                s_clk,
    input  logic                s_rst,
    input  logic                wr_en,
    input  logic                wr_bank,
    input  systolic_pkg::elem_t wr_weight,
    input  logic                calc_bank,
    input  logic                in_valid,
    input  systolic_pkg::elem_t in_data,
    input  systolic_pkg::acc_t  in_psum,
    output logic                out_valid,
    output systolic_pkg::elem_t out_data,
    output systolic_pkg::acc_t  out_psum
);
    import systolic_pkg::*;

    elem_t weight [2];
    elem_t cur_weight;

    // two banks, so loading and computing overlap
    always_ff @(posedge s_clk) begin
        if (wr_en) begin
            weight[wr_bank] <= wr_weight;
        end
    end

    assign cur_weight = weight[calc_bank];

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // activation moves right, psum moves down, one stage each
    always_ff @(posedge s_clk) begin
        out_data <= in_data;
        if (in_valid) begin
            out_psum <= in_psum + acc_t'(in_data) * acc_t'(cur_weight);
        end else begin
            out_psum <= in_psum;
        end
    end

endmodule

`default_nettype wire

/* hw/weight_loader.sv */
// B blocks must carry exactly SIZE beats, done on the last; at most two blocks held
`timescale 1ns/10ps
`default_nettype none

module weight_loader #(
    parameter int SIZE   = 4,
    parameter int DATA_W = 8
) (
    input  logic                   s_clk,
    input  logic                   s_rst,
    slice_if.sink                  b,
    input  logic                   calc_done,
    output logic [SIZE-1:0]        wr_row_sel,
    output logic [SIZE*DATA_W-1:0] wr_row_data,
    output logic                   wr_bank,
    output logic                   calc_bank,
    output logic                   bank_ready
);
    logic [1:0]      load_ptr;
    logic [1:0]      calc_ptr;
    logic [1:0]      load_ptr_nxt;
    logic [1:0]      calc_ptr_nxt;
    logic            full_nxt;
    logic [SIZE-1:0] row_sel;
    logic            b_fire;
    logic            b_last;

    assign b_fire = b.valid && b.ready;
    assign b_last = b_fire && b.done;

    assign load_ptr_nxt = load_ptr + {1'b0, b_last};
    assign calc_ptr_nxt = calc_ptr + {1'b0, calc_done};

    // both banks hold weights not yet consumed
    assign full_nxt = (load_ptr_nxt[1] != calc_ptr_nxt[1])
                   && (load_ptr_nxt[0] == calc_ptr_nxt[0]);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            load_ptr <= 2'b00;
            calc_ptr <= 2'b00;
            row_sel  <= SIZE'(1);
            b.ready  <= 1'b0;
        end else begin
            load_ptr <= load_ptr_nxt;
            calc_ptr <= calc_ptr_nxt;
            // restart at row 0 after the done beat
            if (b_last) begin
                row_sel <= SIZE'(1);
            end else if (b_fire) begin
                row_sel <= row_sel << 1;
            end
            b.ready <= !full_nxt;
        end
    end

    // slice goes straight into the selected grid row
    assign wr_row_sel  = b_fire ? row_sel : '0;
    assign wr_row_data = b.data;
    assign wr_bank     = load_ptr[0];
    assign calc_bank   = calc_ptr[0];
    assign bank_ready  = load_ptr != calc_ptr;

endmodule

`default_nettype wire

/* hw/act_skew_feeder.sv */
// holds one A block of exactly SIZE beats; the next block is taken once feeding ends
`timescale 1ns/10ps
`default_nettype none

module act_skew_feeder #(
    parameter int SIZE   = 4,
    parameter int DATA_W = 8
) (
    input  logic                   s_clk,
    input  logic                   s_rst,
    slice_if.sink                  a,
    input  logic                   feed_start,
    output logic                   block_ready,
    output logic [SIZE-1:0]        feed_valid,
    output logic [SIZE*DATA_W-1:0] feed_data
);
    localparam int IDX_W    = (SIZE > 1) ? $clog2(SIZE) : 1;
    localparam int CNT_W    = $clog2(2 * SIZE);
    localparam int LAST_CYC = 2 * SIZE - 2;

    logic [SIZE*DATA_W-1:0] a_buf [SIZE];
    logic [IDX_W-1:0]       wr_idx;
    logic                   buf_full;
    logic                   feed_active;
    logic [CNT_W-1:0]       feed_cnt;
    logic                   a_fire;
    logic                   feed_end;

    assign a_fire   = a.valid && a.ready;
    assign feed_end = feed_active && (feed_cnt == CNT_W'(LAST_CYC));

    // row store, indexed by beat number
    always_ff @(posedge s_clk) begin
        if (a_fire) begin
            a_buf[wr_idx] <= a.data;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_idx      <= '0;
            buf_full    <= 1'b0;
            a.ready     <= 1'b0;
            feed_active <= 1'b0;
            feed_cnt    <= '0;
        end else begin
            if (a_fire) begin
                wr_idx <= a.done ? '0 : wr_idx + 1'b1;
            end
            if (a_fire && a.done) begin
                buf_full <= 1'b1;
                a.ready  <= 1'b0;
            end else if (feed_end) begin
                buf_full <= 1'b0;
                a.ready  <= 1'b1;
            end else begin
                a.ready <= !buf_full;
            end
            // skew counter, last lane done at 2*SIZE-2
            if (feed_start) begin
                feed_active <= 1'b1;
                feed_cnt    <= '0;
            end else if (feed_end) begin
                feed_active <= 1'b0;
            end else if (feed_active) begin
                feed_cnt <= feed_cnt + 1'b1;
            end
        end
    end

    assign block_ready = buf_full && !feed_active;

    // lane k carries element k of row (feed_cnt - k)
    always_comb begin
        int row_i;
        feed_data = '0;
        for (int k = 0; k < SIZE; k++) begin
            row_i         = int'(feed_cnt) - k;
            feed_valid[k] = feed_active && (row_i >= 0) && (row_i < SIZE);
            if (feed_valid[k]) begin
                feed_data[k*DATA_W +: DATA_W] = a_buf[row_i][k*DATA_W +: DATA_W];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/systolic_array.sv */
// one block in flight at a time; the next feed waits until all result rows are taken
`timescale 1ns/10ps
`default_nettype none

module systolic_array #(
    parameter int SIZE   = systolic_pkg::SIZE_DEFAULT,
    parameter int DATA_W = systolic_pkg::DATA_W
) (
    input  logic                                s_clk,
    input  logic                                s_rst,
    slice_if.sink                               a,
    slice_if.sink                               b,
    output logic                                res_valid,
    output logic [SIZE*systolic_pkg::ACC_W-1:0] res_data,
    output logic                                res_last,
    input  logic                                res_ready
);
    import systolic_pkg::*;

    localparam int IDX_W = (SIZE > 1) ? $clog2(SIZE) : 1;
    localparam int CNT_W = $clog2(2 * SIZE);

    ctrl_state_t            state;
    ctrl_state_t            state_nxt;
    logic [CNT_W-1:0]       phase_cnt;
    logic [IDX_W-1:0]       out_row;
    logic [IDX_W-1:0]       wr_row;
    logic                   feed_start;
    logic                   calc_done;
    logic                   bank_ready;
    logic                   block_ready;
    logic [SIZE-1:0]        wr_row_sel;
    logic [SIZE*DATA_W-1:0] wr_row_data;
    logic                   wr_bank;
    logic                   calc_bank;
    logic [SIZE-1:0]        feed_valid;
    logic [SIZE*DATA_W-1:0] feed_data;
    logic                   out_fire;

    // grid nets: activations along rows, psums down columns
    logic                   act_vld [SIZE][SIZE+1];
    elem_t                  act_dat [SIZE][SIZE+1];
    acc_t                   psum    [SIZE+1][SIZE];

    logic [SIZE*ACC_W-1:0]  row_aligned;
    logic                   row_wr;
    logic [SIZE*ACC_W-1:0]  res_buf [SIZE];

    weight_loader #(
        .SIZE   (SIZE),
        .DATA_W (DATA_W)
    ) loader_i (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .b           (b),
        .calc_done   (calc_done),
        .wr_row_sel  (wr_row_sel),
        .wr_row_data (wr_row_data),
        .wr_bank     (wr_bank),
        .calc_bank   (calc_bank),
        .bank_ready  (bank_ready)
    );

    act_skew_feeder #(
        .SIZE   (SIZE),
        .DATA_W (DATA_W)
    ) feeder_i (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .a           (a),
        .feed_start  (feed_start),
        .block_ready (block_ready),
        .feed_valid  (feed_valid),
        .feed_data   (feed_data)
    );

    always_comb begin
        state_nxt  = state;
        feed_start = 1'b0;
        calc_done  = 1'b0;
        case (state)
            IDLE: begin
                state_nxt = WAIT_OPERANDS;
            end
            WAIT_OPERANDS: begin
                if (bank_ready && block_ready) begin
                    state_nxt  = FEED;
                    feed_start = 1'b1;
                end
            end
            FEED: begin
                if (phase_cnt == CNT_W'(SIZE - 1)) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                // last activation has left the grid, weight bank is free
                if (phase_cnt == CNT_W'(2 * SIZE - 2)) begin
                    state_nxt = OUTPUT;
                    calc_done = 1'b1;
                end
            end
            OUTPUT: begin
                if (out_fire && res_last) begin
                    state_nxt = WAIT_OPERANDS;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state     <= IDLE;
            phase_cnt <= '0;
            out_row   <= '0;
            wr_row    <= '0;
        end else begin
            state <= state_nxt;
            if (state != state_nxt) begin
                phase_cnt <= '0;
            end else if (state == FEED || state == DRAIN) begin
                phase_cnt <= phase_cnt + 1'b1;
            end
            if (out_fire) begin
                out_row <= res_last ? '0 : out_row + 1'b1;
            end
            if (row_wr) begin
                wr_row <= (wr_row == IDX_W'(SIZE - 1)) ? '0 : wr_row + 1'b1;
            end
        end
    end

    for (genvar r = 0; r < SIZE; r++) begin : g_row
        assign act_vld[r][0] = feed_valid[r];
        assign act_dat[r][0] = feed_data[r*DATA_W +: DATA_W];
        for (genvar c = 0; c < SIZE; c++) begin : g_col
            systolic_pe pe_i (
                .s_clk     (s_clk),
                .s_rst     (s_rst),
                .wr_en     (wr_row_sel[r]),
                .wr_bank   (wr_bank),
                .wr_weight (wr_row_data[c*DATA_W +: DATA_W]),
                .calc_bank (calc_bank),
                .in_valid  (act_vld[r][c]),
                .in_data   (act_dat[r][c]),
                .in_psum   (psum[r][c]),
                .out_valid (act_vld[r][c+1]),
                .out_data  (act_dat[r][c+1]),
                .out_psum  (psum[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < SIZE; c++) begin : g_deskew
        localparam int DEPTH = SIZE - 1 - c;
        assign psum[0][c] = '0;
        if (DEPTH == 0) begin : g_direct
            assign row_aligned[c*ACC_W +: ACC_W] = psum[SIZE][c];
        end else begin : g_delay
            acc_t dly [DEPTH];
            always_ff @(posedge s_clk) begin
                dly[0] <= psum[SIZE][c];
                for (int n = 1; n < DEPTH; n++) begin
                    dly[n] <= dly[n-1];
                end
            end
            assign row_aligned[c*ACC_W +: ACC_W] = dly[DEPTH-1];
        end
    end

    // bottom-right valid lines up with the deskewed row
    assign row_wr = act_vld[SIZE-1][SIZE];

    always_ff @(posedge s_clk) begin
        if (row_wr) begin
            res_buf[wr_row] <= row_aligned;
        end
    end

    assign res_valid = (state == OUTPUT);
    assign res_data  = res_buf[out_row];
    assign res_last  = res_valid && (out_row == IDX_W'(SIZE - 1));
    assign out_fire  = res_valid && res_ready;

endmodule

`default_nettype wire

/* hw/systolic_mm_top.sv */
// unsigned C = A x B on SIZE x SIZE blocks; k-th A pairs with k-th B in arrival order
`timescale 1ns/10ps
`default_nettype none

module systolic_mm_top #(
    parameter int SIZE   = systolic_pkg::SIZE_DEFAULT,
    parameter int DATA_W = systolic_pkg::DATA_W
) (
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  logic                                a_valid,
    input  logic [SIZE*DATA_W-1:0]              a_data,
    input  logic                                a_done,
    output logic                                a_ready,
    input  logic                                b_valid,
    input  logic [SIZE*DATA_W-1:0]              b_data,
    input  logic                                b_done,
    output logic                                b_ready,
    output logic                                res_valid,
    output logic [SIZE*systolic_pkg::ACC_W-1:0] res_data,
    output logic                                res_last,
    input  logic                                res_ready
);
    slice_if #(.W(SIZE * DATA_W)) a_if ();
    slice_if #(.W(SIZE * DATA_W)) b_if ();

    // A stream
    assign a_if.valid = a_valid;
    assign a_if.data  = a_data;
    assign a_if.done  = a_done;
    assign a_ready    = a_if.ready;

    // B stream
    assign b_if.valid = b_valid;
    assign b_if.data  = b_data;
    assign b_if.done  = b_done;
    assign b_ready    = b_if.ready;

    systolic_array #(
        .SIZE   (SIZE),
        .DATA_W (DATA_W)
    ) array_i (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .a         (a_if.sink),
        .b         (b_if.sink),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_last  (res_last),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

/* testbench/tb_systolic_mm.sv */
// SIZE fixed at 4; reference products use plain integers; stops at the first mismatch
`timescale 1ns/10ps
`default_nettype none

module tb_systolic_mm;
    import systolic_pkg::*;

    localparam int SIZE            = 4;
    localparam int SLICE_W         = SIZE * DATA_W;
    localparam int ROW_W           = SIZE * ACC_W;
    localparam int BLOCK_W         = SIZE * SLICE_W;
    localparam int NUM_BLOCKS      = 20;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 200 + 1000;

    // whole block packed, element (i,j) at (i*SIZE+j)*DATA_W
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [ROW_W-1:0]   row_t;

    logic               s_clk;
    logic               s_rst;
    logic               a_valid;
    logic [SLICE_W-1:0] a_data;
    logic               a_done;
    logic               a_ready;
    logic               b_valid;
    logic [SLICE_W-1:0] b_data;
    logic               b_done;
    logic               b_ready;
    logic               res_valid;
    row_t               res_data;
    logic               res_last;
    logic               res_ready;

    // sent blocks, paired by index
    block_t a_q [$];
    block_t b_q [$];

    int     res_blk   = 0;
    int     res_row   = 0;
    logic   exp_have  = 1'b0;
    logic   exp_last  = 1'b0;
    row_t   exp_data  = '0;
    logic   hold_prev = 1'b0;
    row_t   data_prev = '0;
    logic   stall_mode;

    systolic_mm_top #(
        .SIZE   (SIZE),
        .DATA_W (DATA_W)
    ) dut_i (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .a_valid   (a_valid),
        .a_data    (a_data),
        .a_done    (a_done),
        .a_ready   (a_ready),
        .b_valid   (b_valid),
        .b_data    (b_data),
        .b_done    (b_done),
        .b_ready   (b_ready),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_last  (res_last),
        .res_ready (res_ready)
    );

    initial begin
        s_clk = 1'b0;
        forever #5 s_clk = ~s_clk;
    end

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic int element_of(input block_t m, input int i, input int j);
        return int'(m[(i*SIZE+j)*DATA_W +: DATA_W]);
    endfunction

    function automatic block_t random_block();
        block_t m;
        for (int e = 0; e < SIZE * SIZE; e++) begin
            m[e*DATA_W +: DATA_W] = DATA_W'($urandom);
        end
        return m;
    endfunction

    function automatic block_t identity_block();
        block_t m;
        m = '0;
        for (int i = 0; i < SIZE; i++) begin
            m[(i*SIZE+i)*DATA_W +: DATA_W] = DATA_W'(1);
        end
        return m;
    endfunction

    function automatic block_t constant_block(input int value);
        block_t m;
        for (int e = 0; e < SIZE * SIZE; e++) begin
            m[e*DATA_W +: DATA_W] = DATA_W'(value);
        end
        return m;
    endfunction

    // row i of C = A x B
    function automatic row_t expected_row(input block_t a, input block_t b, input int i);
        row_t row;
        int   sum;
        for (int j = 0; j < SIZE; j++) begin
            sum = 0;
            for (int k = 0; k < SIZE; k++) begin
                sum += element_of(a, i, k) * element_of(b, k, j);
            end
            row[j*ACC_W +: ACC_W] = ACC_W'(sum);
        end
        return row;
    endfunction

    // called on a falling edge, returns on the falling edge after the done beat
    task automatic send_a_block(input block_t m, input int gap_pct);
        a_q.push_back(m);
        for (int i = 0; i < SIZE; i++) begin
            while ($urandom_range(0, 99) < gap_pct) begin
                a_valid = 1'b0;
                @(negedge s_clk);
            end
            a_valid = 1'b1;
            a_data  = m[i*SLICE_W +: SLICE_W];
            a_done  = (i == SIZE - 1);
            while (!a_ready) @(negedge s_clk);
            @(negedge s_clk);
        end
        a_valid = 1'b0;
        a_done  = 1'b0;
    endtask

    task automatic load_b_block(input block_t m, input int gap_pct);
        b_q.push_back(m);
        for (int i = 0; i < SIZE; i++) begin
            while ($urandom_range(0, 99) < gap_pct) begin
                b_valid = 1'b0;
                @(negedge s_clk);
            end
            b_valid = 1'b1;
            b_data  = m[i*SLICE_W +: SLICE_W];
            b_done  = (i == SIZE - 1);
            while (!b_ready) @(negedge s_clk);
            @(negedge s_clk);
        end
        b_valid = 1'b0;
        b_done  = 1'b0;
    endtask

    task automatic send_pairs(input int count, input int gap_pct);
        fork
            begin
                for (int n = 0; n < count; n++) send_a_block(random_block(), gap_pct);
            end
            begin
                for (int n = 0; n < count; n++) load_b_block(random_block(), gap_pct);
            end
        join
    endtask

    task automatic wait_results(input int target);
        while (res_blk < target) @(negedge s_clk);
    endtask

    // result sink, random stalls when stall_mode is set
    initial begin
        res_ready = 1'b0;
        forever begin
            @(negedge s_clk);
            res_ready = stall_mode ? ($urandom_range(0, 99) < 40) : 1'b1;
        end
    end

    // tracks which C row is due next and what it must hold
    always @(posedge s_clk) begin
        int nxt_row;
        int nxt_blk;
        nxt_row = res_row;
        nxt_blk = res_blk;
        if (!s_rst && res_valid && res_ready) begin
            if (res_row == SIZE - 1) begin
                nxt_row = 0;
                nxt_blk = res_blk + 1;
            end else begin
                nxt_row = res_row + 1;
            end
        end
        res_row   <= nxt_row;
        res_blk   <= nxt_blk;
        exp_last  <= (nxt_row == SIZE - 1);
        hold_prev <= !s_rst && res_valid && !res_ready;
        data_prev <= res_data;
        if (nxt_blk < a_q.size() && nxt_blk < b_q.size()) begin
            exp_have <= 1'b1;
            exp_data <= expected_row(a_q[nxt_blk], b_q[nxt_blk], nxt_row);
        end else begin
            exp_have <= 1'b0;
        end
    end

    row_value_check: assert property (@(posedge s_clk) disable iff (s_rst)
        (res_valid && res_ready) |-> (exp_have && (res_data == exp_data)))
        else report_failure($sformatf("block %0d row %0d differs from reference",
                                      res_blk, res_row));

    // last flag only on the final valid row
    row_last_check: assert property (@(posedge s_clk) disable iff (s_rst)
        res_last == (res_valid && exp_last))
        else report_failure($sformatf("res_last wrong on row %0d", res_row));

    // held row must not change while the sink stalls
    hold_check: assert property (@(posedge s_clk) disable iff (s_rst)
        hold_prev |-> (res_valid && (res_data == data_prev)))
        else report_failure("result row changed under back-pressure");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge s_clk);
        $display("timeout: results did not arrive");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int wait_cyc;
        s_rst      = 1'b1;
        a_valid    = 1'b0;
        a_data     = '0;
        a_done     = 1'b0;
        b_valid    = 1'b0;
        b_data     = '0;
        b_done     = 1'b0;
        stall_mode = 1'b0;
        void'($urandom(32'h7827));
        repeat (5) @(posedge s_clk);
        @(negedge s_clk);
        s_rst = 1'b0;
        assert (!res_valid && !a_ready && !b_ready)
            else report_failure("outputs not low right after reset");
        wait_cyc = 0;
        while (!(a_ready && b_ready) && wait_cyc < 4) begin
            @(negedge s_clk);
            wait_cyc++;
        end
        assert (a_ready && b_ready)
            else report_failure("a_ready or b_ready did not rise after reset");

        // one random product
        send_pairs(1, 0);
        wait_results(1);

        // identity weights, then all-maximum operands
        fork
            send_a_block(random_block(), 0);
            load_b_block(identity_block(), 0);
        join
        fork
            send_a_block(constant_block(255), 0);
            load_b_block(constant_block(255), 0);
        join
        wait_results(3);

        // both weight banks filled before any A arrives
        load_b_block(random_block(), 0);
        load_b_block(random_block(), 0);
        repeat (8) begin
            @(negedge s_clk);
            assert (!b_ready) else report_failure("b_ready high with two B blocks pending");
        end
        send_pairs(3, 30);
        wait_results(6);

        // random stalls on the result side
        stall_mode = 1'b1;
        send_pairs(4, 0);
        wait_results(10);
        stall_mode = 1'b0;

        // random gaps on both operand streams
        send_pairs(10, 40);
        wait_results(NUM_BLOCKS);

        // two spare B blocks stay buffered, A side and result side empty
        repeat (5) @(negedge s_clk);
        if (!res_valid && a_ready && !b_ready) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("handshake state wrong after the last block: res_valid %0b a_ready %0b b_ready %0b",
                     res_valid, a_ready, b_ready);
            $display("Testbench failed");
            $fatal(1, "wrong idle state");
        end
    end

endmodule

`default_nettype wire

/* list.f */
hw/systolic_pkg.sv
hw/slice_if.sv
hw/systolic_pe.sv
hw/weight_loader.sv
hw/act_skew_feeder.sv
hw/systolic_array.sv
hw/systolic_mm_top.sv
testbench/tb_systolic_mm.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the systolic multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_systolic_mm \
    -o tb_systolic_mm

./obj_dir/tb_systolic_mm 2>&1 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1
